// File: hw/adxl355_pkg.sv
package adxl355_pkg;

	// i_clk cycles per quarter of an SCL bit
	// kept small so that simulation runs quickly
	localparam int QTR_DIV = 4;

	// 7-bit device address with ASEL tied low
	localparam logic [6:0] DEV_ADDR = 7'h1D;

	// the burst starts at TEMP2 and runs through ZDATA1
	localparam logic [7:0] REG_TEMP2 = 8'h06;
	localparam int BURST_LEN = 11;

	// CPU transfer kind
	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} op_t;

	// 12-bit raw temperature
	typedef logic [11:0] temp_t;

	// 20-bit two's complement acceleration
	typedef logic signed [19:0] axis_t;

	// quarter of the current SCL bit
	// SCL is low in the two LOW quarters and released in the HIGH ones
	typedef enum logic [1:0] {
		PH_LOW0  = 2'd0,
		PH_LOW1  = 2'd1,
		PH_HIGH0 = 2'd2,
		PH_HIGH1 = 2'd3
	} phase_t;

endpackage

// File: hw/i2c_bit_timer.sv
`timescale 1ns/10ps

module i2c_bit_timer import adxl355_pkg::*; (
	input  logic   i_clk,
	input  logic   i_rst_n,
	input  logic   i_run,
	output logic   o_tick,
	output phase_t o_phase
);

	// position inside the current quarter
	logic [$clog2(QTR_DIV)-1:0] div_cnt;

	// tick marks the last cycle of the quarter named by o_phase
	assign o_tick = i_run && (div_cnt == ($clog2(QTR_DIV))'(QTR_DIV - 1));

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			div_cnt <= '0;
			o_phase <= PH_LOW0;
		end else if (!i_run) begin
			// bus idle, restart at the first low quarter
			div_cnt <= '0;
			o_phase <= PH_LOW0;
		end else if (o_tick) begin
			div_cnt <= '0;
			o_phase <= phase_t'(o_phase + 2'd1);
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

// File: hw/i2c_seq_fsm.sv
`timescale 1ns/10ps

module i2c_seq_fsm import adxl355_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_start,
	input  op_t        i_op,
	input  logic [7:0] i_reg_addr,
	input  logic [7:0] i_wr_data,
	input  logic       i_drdy,
	input  logic       i_tick,
	input  phase_t     i_phase,
	input  logic       i_sda,
	input  logic       i_byte_end,
	input  logic [7:0] i_rx_byte,
	output logic       o_run,
	output logic       o_load,
	output logic [7:0] o_load_byte,
	output logic       o_read_mode,
	output logic       o_scl_oe,
	output logic       o_start_stop_sda,
	output logic       o_busy,
	output logic       o_done,
	output logic       o_nack,
	output logic [7:0] o_rd_data,
	output logic       o_rx_valid,
	output logic [3:0] o_byte_idx,
	output logic       o_commit
);

	typedef enum logic [3:0] {
		ST_IDLE, ST_START, ST_ADDR, ST_ADDR_ACK, ST_PTR, ST_PTR_ACK,
		ST_WRITE, ST_WRITE_ACK, ST_READ, ST_MACK, ST_STOP
	} state_t;

	state_t     state;
	state_t     state_d;
	logic       accept;
	logic       slot_end;
	logic       ack_slot;
	logic       need_read;
	logic       again;
	logic       last_byte;
	logic       rd_phase;
	logic       is_burst;
	op_t        req_op;
	logic [7:0] req_reg;
	logic [7:0] req_data;
	logic       byte_seen;
	logic       nack_seen;

	// CPU request wins over data-ready
	assign accept    = (state == ST_IDLE) && (i_start || i_drdy);
	// state changes only at the end of a bit slot
	assign slot_end  = i_tick && (i_phase == PH_HIGH1);
	assign ack_slot  = (state == ST_ADDR_ACK) || (state == ST_PTR_ACK) || (state == ST_WRITE_ACK);
	assign need_read = is_burst || (req_op == OP_READ);
	// pointer transaction done, the read transaction follows
	assign again     = need_read && !rd_phase && !nack_seen;
	assign last_byte = !is_burst || (o_byte_idx == 4'(BURST_LEN - 1));

	assign o_run       = (state != ST_IDLE);
	assign o_read_mode = (state == ST_READ);
	assign o_rx_valid  = (state == ST_READ) && i_byte_end && is_burst;
	assign o_commit    = (state == ST_STOP) && (state_d == ST_IDLE) && is_burst && !nack_seen;

	always_comb begin
		state_d = state;
		case (state)
			ST_IDLE: begin
				if (accept) state_d = ST_START;
			end
			ST_START: begin
				if (slot_end) state_d = ST_ADDR;
			end
			ST_ADDR: begin
				if (slot_end && byte_seen) state_d = ST_ADDR_ACK;
			end
			ST_ADDR_ACK: begin
				if (slot_end) begin
					if (nack_seen) state_d = ST_STOP;
					else if (rd_phase) state_d = ST_READ;
					else state_d = ST_PTR;
				end
			end
			ST_PTR: begin
				if (slot_end && byte_seen) state_d = ST_PTR_ACK;
			end
			ST_PTR_ACK: begin
				if (slot_end) state_d = (nack_seen || need_read) ? ST_STOP : ST_WRITE;
			end
			ST_WRITE: begin
				if (slot_end && byte_seen) state_d = ST_WRITE_ACK;
			end
			ST_WRITE_ACK: begin
				if (slot_end) state_d = ST_STOP;
			end
			ST_READ: begin
				if (slot_end && byte_seen) state_d = ST_MACK;
			end
			ST_MACK: begin
				if (slot_end) state_d = last_byte ? ST_STOP : ST_READ;
			end
			ST_STOP: begin
				if (slot_end) state_d = again ? ST_START : ST_IDLE;
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= ST_IDLE;
			rd_phase   <= 1'b0;
			is_burst   <= 1'b0;
			req_op     <= OP_WRITE;
			byte_seen  <= 1'b0;
			nack_seen  <= 1'b0;
			o_byte_idx <= '0;
			o_load     <= 1'b0;
			o_busy     <= 1'b0;
			o_done     <= 1'b0;
			o_nack     <= 1'b0;
			o_rd_data  <= '0;
		end else begin
			state  <= state_d;
			o_done <= 1'b0;
			// new byte for the shifter on entry to a byte state
			o_load <= (state_d != state) && ((state_d == ST_ADDR) || (state_d == ST_PTR) ||
				(state_d == ST_WRITE) || (state_d == ST_READ));
			if (state_d != state) begin
				byte_seen <= 1'b0;
			end else if (i_byte_end) begin
				byte_seen <= 1'b1;
			end
			if (accept) begin
				is_burst   <= !i_start;
				req_op     <= i_op;
				rd_phase   <= 1'b0;
				nack_seen  <= 1'b0;
				o_byte_idx <= '0;
				o_busy     <= 1'b1;
				o_nack     <= 1'b0;
			end
			// slave ACK is sampled mid-high
			if (ack_slot && i_tick && (i_phase == PH_HIGH0) && i_sda) begin
				nack_seen <= 1'b1;
			end
			if ((state == ST_STOP) && (state_d == ST_START)) begin
				rd_phase <= 1'b1;
			end
			if ((state == ST_STOP) && (state_d == ST_IDLE)) begin
				o_busy <= 1'b0;
				o_done <= 1'b1;
				o_nack <= nack_seen;
			end
			if ((state == ST_MACK) && (state_d == ST_READ)) begin
				o_byte_idx <= o_byte_idx + 4'd1;
			end
			if ((state == ST_READ) && i_byte_end && !is_burst) begin
				o_rd_data <= i_rx_byte;
			end
		end
	end

	// SCL and the FSM's own SDA pull are registered so the bus never glitches
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_scl_oe         <= 1'b0;
			o_start_stop_sda <= 1'b0;
		end else begin
			if (i_tick && (i_phase == PH_LOW1)) begin
				o_scl_oe <= 1'b0;
			end else if (slot_end) begin
				// start slot keeps SCL high for its whole length
				o_scl_oe <= (state_d != ST_START) && (state_d != ST_IDLE);
			end
			if (i_tick && (i_phase == PH_LOW0)) begin
				case (state)
					ST_MACK: o_start_stop_sda <= !last_byte;
					ST_STOP: o_start_stop_sda <= 1'b1;
					default: o_start_stop_sda <= 1'b0;
				endcase
			end else if (i_tick && (i_phase == PH_HIGH0)) begin
				// start falls and stop rises while SCL is high
				if (state == ST_START) o_start_stop_sda <= 1'b1;
				else if (state == ST_STOP) o_start_stop_sda <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (accept) begin
			req_reg  <= i_reg_addr;
			req_data <= i_wr_data;
		end
		case (state_d)
			ST_ADDR:  o_load_byte <= {DEV_ADDR, rd_phase};
			ST_PTR:   o_load_byte <= is_burst ? REG_TEMP2 : req_reg;
			ST_WRITE: o_load_byte <= req_data;
			default:  o_load_byte <= 8'hFF;
		endcase
	end

endmodule

// File: hw/i2c_byte_shifter.sv
`timescale 1ns/10ps

module i2c_byte_shifter import adxl355_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_load,
	input  logic [7:0] i_load_byte,
	input  logic       i_read_mode,
	input  logic       i_tick,
	input  phase_t     i_phase,
	input  logic       i_sda,
	input  logic       i_start_stop_sda,
	output logic       o_sda_oe,
	output logic       o_byte_end,
	output logic [7:0] o_rx_byte
);

	logic [7:0] shift_q;
	logic [2:0] bit_cnt;
	logic       active;
	logic       sda_drv;
	logic       sample;

	// mid-high of a bit that belongs to the byte
	assign sample = active && i_tick && (i_phase == PH_HIGH0);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bit_cnt    <= '0;
			active     <= 1'b0;
			sda_drv    <= 1'b0;
			o_byte_end <= 1'b0;
		end else begin
			o_byte_end <= 1'b0;
			// SDA moves only in the middle of the low half
			// released for read bits and for the ack slot after a byte
			if (i_tick && (i_phase == PH_LOW0)) begin
				sda_drv <= active && !i_read_mode && !shift_q[7];
			end
			if (i_load) begin
				active  <= 1'b1;
				bit_cnt <= '0;
			end else if (sample) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					active     <= 1'b0;
					o_byte_end <= 1'b1;
				end
			end
		end
	end

	// MSB first in both directions
	always_ff @(posedge i_clk) begin
		if (i_load) begin
			shift_q <= i_load_byte;
		end else if (sample) begin
			shift_q <= {shift_q[6:0], i_sda};
		end
	end

	assign o_rx_byte = shift_q;
	assign o_sda_oe  = sda_drv | i_start_stop_sda;

endmodule

// File: hw/sensor_sample_reg.sv
`timescale 1ns/10ps

module sensor_sample_reg import adxl355_pkg::*; #(
	parameter type T         = axis_t,
	parameter int  FIRST_IDX = 2
) (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_rx_valid,
	input  logic [3:0] i_byte_idx,
	input  logic [7:0] i_rx_byte,
	input  logic       i_commit,
	output T           o_sample
);

	logic [7:0]  byte0;
	logic [7:0]  byte1;
	logic [7:0]  byte2;
	logic [23:0] staged;
	T            assembled;

	always_ff @(posedge i_clk) begin
		if (i_rx_valid) begin
			if (i_byte_idx == 4'(FIRST_IDX)) byte0 <= i_rx_byte;
			if (i_byte_idx == 4'(FIRST_IDX + 1)) byte1 <= i_rx_byte;
			if (i_byte_idx == 4'(FIRST_IDX + 2)) byte2 <= i_rx_byte;
		end
	end

	assign staged = {byte0, byte1, byte2};

	if ($bits(T) > 16) begin : g_axis
		// data3, data2 and the upper nibble of data1
		assign assembled = T'(staged[23:4]);
	end else begin : g_temp
		// low nibble of TEMP2 then TEMP1
		assign assembled = T'(staged[19:8]);
	end

	// all samples of a burst switch together
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_sample <= '0;
		end else if (i_commit) begin
			o_sample <= assembled;
		end
	end

endmodule

// File: hw/adxl355_i2c_top.sv
`timescale 1ns/10ps

module adxl355_i2c_top import adxl355_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_start,
	input  op_t        i_op,
	input  logic [7:0] i_reg_addr,
	input  logic [7:0] i_wr_data,
	input  logic       i_drdy,
	output logic       o_busy,
	output logic       o_done,
	output logic       o_nack,
	output logic [7:0] o_rd_data,
	output temp_t      o_temp,
	output axis_t      o_acc_x,
	output axis_t      o_acc_y,
	output axis_t      o_acc_z,
	output logic       o_scl_oe,
	output logic       o_sda_oe,
	input  logic       i_sda
);

	logic       run;
	logic       tick;
	phase_t     phase;
	logic       load;
	logic [7:0] load_byte;
	logic       read_mode;
	logic       start_stop_sda;
	logic       byte_end;
	logic [7:0] rx_byte;
	logic       rx_valid;
	logic [3:0] byte_idx;
	logic       commit;

	i2c_bit_timer u_timer (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_run   (run),
		.o_tick  (tick),
		.o_phase (phase)
	);

	i2c_seq_fsm u_fsm (
		.i_clk            (i_clk),
		.i_rst_n          (i_rst_n),
		.i_start          (i_start),
		.i_op             (i_op),
		.i_reg_addr       (i_reg_addr),
		.i_wr_data        (i_wr_data),
		.i_drdy           (i_drdy),
		.i_tick           (tick),
		.i_phase          (phase),
		.i_sda            (i_sda),
		.i_byte_end       (byte_end),
		.i_rx_byte        (rx_byte),
		.o_run            (run),
		.o_load           (load),
		.o_load_byte      (load_byte),
		.o_read_mode      (read_mode),
		.o_scl_oe         (o_scl_oe),
		.o_start_stop_sda (start_stop_sda),
		.o_busy           (o_busy),
		.o_done           (o_done),
		.o_nack           (o_nack),
		.o_rd_data        (o_rd_data),
		.o_rx_valid       (rx_valid),
		.o_byte_idx       (byte_idx),
		.o_commit         (commit)
	);

	i2c_byte_shifter u_shifter (
		.i_clk            (i_clk),
		.i_rst_n          (i_rst_n),
		.i_load           (load),
		.i_load_byte      (load_byte),
		.i_read_mode      (read_mode),
		.i_tick           (tick),
		.i_phase          (phase),
		.i_sda            (i_sda),
		.i_start_stop_sda (start_stop_sda),
		.o_sda_oe         (o_sda_oe),
		.o_byte_end       (byte_end),
		.o_rx_byte        (rx_byte)
	);

	// burst bytes 0..1 temperature, 2..10 X, Y, Z
	sensor_sample_reg #(.T(temp_t), .FIRST_IDX(0)) u_temp (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_rx_valid (rx_valid),
		.i_byte_idx (byte_idx),
		.i_rx_byte  (rx_byte),
		.i_commit   (commit),
		.o_sample   (o_temp)
	);

	sensor_sample_reg #(.T(axis_t), .FIRST_IDX(2)) u_acc_x (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_rx_valid (rx_valid),
		.i_byte_idx (byte_idx),
		.i_rx_byte  (rx_byte),
		.i_commit   (commit),
		.o_sample   (o_acc_x)
	);

	sensor_sample_reg #(.T(axis_t), .FIRST_IDX(5)) u_acc_y (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_rx_valid (rx_valid),
		.i_byte_idx (byte_idx),
		.i_rx_byte  (rx_byte),
		.i_commit   (commit),
		.o_sample   (o_acc_y)
	);

	sensor_sample_reg #(.T(axis_t), .FIRST_IDX(8)) u_acc_z (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_rx_valid (rx_valid),
		.i_byte_idx (byte_idx),
		.i_rx_byte  (rx_byte),
		.i_commit   (commit),
		.o_sample   (o_acc_z)
	);

endmodule

// File: sim/adxl355_slave_model.sv
`timescale 1ns/10ps

module adxl355_slave_model import adxl355_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_scl_oe,
	input  logic       i_sda_oe,
	input  logic       i_mute,
	input  logic       i_pre_we,
	input  logic [7:0] i_pre_addr,
	input  logic [7:0] i_pre_data,
	output logic       o_sda
);

	typedef enum logic [2:0] {
		M_IDLE, M_ADDR, M_PTR, M_WDATA, M_RDATA
	} mode_t;

	logic [7:0] regs [256];
	mode_t      mode;
	logic [3:0] bit_cnt;
	logic [7:0] shreg;
	logic [7:0] ptr;
	logic       rw;
	logic       slave_oe;
	logic       scl;
	logic       sda;
	logic       scl_q;
	logic       sda_q;
	logic       start_ev;
	logic       stop_ev;
	logic       rise;
	logic       fall;

	// open-drain lines with pull-ups
	assign scl   = !i_scl_oe;
	assign sda   = !(i_sda_oe || slave_oe);
	assign o_sda = sda;

	// bus events seen one i_clk after they happen
	assign start_ev = scl && scl_q && sda_q && !sda;
	assign stop_ev  = scl && scl_q && !sda_q && sda;
	assign rise     = scl && !scl_q;
	assign fall     = !scl && scl_q;

	always @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mode     <= M_IDLE;
			bit_cnt  <= '0;
			shreg    <= '0;
			ptr      <= '0;
			rw       <= 1'b0;
			slave_oe <= 1'b0;
			scl_q    <= 1'b1;
			sda_q    <= 1'b1;
		end else begin
			scl_q <= scl;
			sda_q <= sda;
			if (i_pre_we) begin
				regs[i_pre_addr] <= i_pre_data;
			end
			if (start_ev) begin
				mode     <= M_ADDR;
				bit_cnt  <= '0;
				slave_oe <= 1'b0;
			end else if (stop_ev) begin
				mode     <= M_IDLE;
				slave_oe <= 1'b0;
			end else if (mode == M_RDATA) begin
				if (rise && bit_cnt == 4'd8) begin
					// master NACK ends the read
					if (sda) mode <= M_IDLE;
					else bit_cnt <= 4'd9;
				end else if (rise) begin
					bit_cnt <= bit_cnt + 4'd1;
				end else if (fall && bit_cnt == 4'd9) begin
					shreg    <= regs[ptr];
					slave_oe <= !regs[ptr][7];
					ptr      <= ptr + 8'd1;
					bit_cnt  <= '0;
				end else if (fall && bit_cnt == 4'd8) begin
					slave_oe <= 1'b0;
				end else if (fall && bit_cnt != 4'd0) begin
					slave_oe <= !shreg[6];
					shreg    <= {shreg[6:0], 1'b0};
				end
			end else if (mode != M_IDLE) begin
				if (rise && bit_cnt < 4'd8) begin
					shreg   <= {shreg[6:0], sda};
					bit_cnt <= bit_cnt + 4'd1;
				end else if (fall && bit_cnt == 4'd8) begin
					bit_cnt  <= 4'd9;
					slave_oe <= 1'b1;
					case (mode)
						M_ADDR: begin
							rw <= shreg[0];
							if (shreg[7:1] != DEV_ADDR || i_mute) begin
								mode     <= M_IDLE;
								slave_oe <= 1'b0;
							end
						end
						M_PTR: ptr <= shreg;
						default: begin
							regs[ptr] <= shreg;
							ptr       <= ptr + 8'd1;
						end
					endcase
				end else if (fall && bit_cnt == 4'd9) begin
					slave_oe <= 1'b0;
					bit_cnt  <= '0;
					if (mode == M_ADDR && rw) begin
						// first read bit goes out right after the ack
						mode     <= M_RDATA;
						shreg    <= regs[ptr];
						slave_oe <= !regs[ptr][7];
						ptr      <= ptr + 8'd1;
					end else if (mode == M_ADDR) begin
						mode <= M_PTR;
					end else begin
						mode <= M_WDATA;
					end
				end
			end
		end
	end

endmodule

// File: sim/adxl355_i2c_assert.sv
`timescale 1ns/10ps

module adxl355_i2c_assert (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_start,
	input logic i_drdy,
	input logic o_busy,
	input logic o_done,
	input logic o_nack,
	input logic o_scl_oe,
	input logic o_sda_oe
);

	done_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_done |=> !o_done)
		else $error("o_done lasted longer than one cycle");

	// bus fully released while idle
	idle_released: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!o_busy |-> (!o_scl_oe && !o_sda_oe))
		else $error("bus driven while o_busy is low");

	nack_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!$stable(o_nack) |-> (o_done || $past(!o_busy && (i_start || i_drdy))))
		else $error("o_nack changed outside o_done or a request");

endmodule

bind adxl355_i2c_top adxl355_i2c_assert u_assert (
	.i_clk    (i_clk),
	.i_rst_n  (i_rst_n),
	.i_start  (i_start),
	.i_drdy   (i_drdy),
	.o_busy   (o_busy),
	.o_done   (o_done),
	.o_nack   (o_nack),
	.o_scl_oe (o_scl_oe),
	.o_sda_oe (o_sda_oe)
);

// File: sim/tb_adxl355_i2c.sv
`timescale 1ns/10ps

module tb_adxl355_i2c import adxl355_pkg::*; ();

	localparam int DONE_TIMEOUT = 6000;

	logic        clk;
	logic        rst_n;
	logic        start;
	op_t         op;
	logic [7:0]  reg_addr;
	logic [7:0]  wr_data;
	logic        drdy;
	logic        busy;
	logic        done;
	logic        nack;
	logic [7:0]  rd_data;
	temp_t       temp;
	axis_t       acc_x;
	axis_t       acc_y;
	axis_t       acc_z;
	logic        scl_oe;
	logic        sda_oe;
	logic        sda;
	logic        mute;
	logic        pre_we;
	logic [7:0]  pre_addr;
	logic [7:0]  pre_data;
	int          errors;
	logic [31:0] lcg_state;
	logic [7:0]  exp_regs [256];
	logic [11:0] last_temp;
	logic [19:0] last_x;
	logic [19:0] last_y;
	logic [19:0] last_z;

	adxl355_i2c_top dut (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_start    (start),
		.i_op       (op),
		.i_reg_addr (reg_addr),
		.i_wr_data  (wr_data),
		.i_drdy     (drdy),
		.o_busy     (busy),
		.o_done     (done),
		.o_nack     (nack),
		.o_rd_data  (rd_data),
		.o_temp     (temp),
		.o_acc_x    (acc_x),
		.o_acc_y    (acc_y),
		.o_acc_z    (acc_z),
		.o_scl_oe   (scl_oe),
		.o_sda_oe   (sda_oe),
		.i_sda      (sda)
	);

	adxl355_slave_model slave (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_scl_oe   (scl_oe),
		.i_sda_oe   (sda_oe),
		.i_mute     (mute),
		.i_pre_we   (pre_we),
		.i_pre_addr (pre_addr),
		.i_pre_data (pre_data),
		.o_sda      (sda)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	task automatic report_mismatch(input string test, input logic [31:0] exp,
		input logic [31:0] act);
		errors++;
		$display("error %s expected 0x%0h actual 0x%0h", test, exp, act);
	endtask

	task automatic wait_done(input string test);
		int n;
		n = 0;
		@(posedge clk);
		while (!done && n < DONE_TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (!done) begin
			errors++;
			$display("error %s: the transfer never finished", test);
		end
	endtask

	task automatic cpu_transfer(input op_t kind, input logic [7:0] addr,
		input logic [7:0] data, input string test);
		@(posedge clk);
		start    <= 1'b1;
		op       <= kind;
		reg_addr <= addr;
		wr_data  <= data;
		@(posedge clk);
		start <= 1'b0;
		wait_done(test);
	endtask

	task automatic pulse_drdy();
		@(posedge clk);
		drdy <= 1'b1;
		@(posedge clk);
		drdy <= 1'b0;
	endtask

	// backdoor load of the slave register file
	task automatic preload_reg(input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk);
		pre_we   <= 1'b1;
		pre_addr <= addr;
		pre_data <= data;
		@(posedge clk);
		pre_we <= 1'b0;
		exp_regs[addr] = data;
	endtask

	task automatic check_samples(input string test);
		if (temp !== last_temp) begin
			report_mismatch({test, " temp"}, {20'd0, last_temp}, {20'd0, temp});
		end
		if (acc_x !== last_x) begin
			report_mismatch({test, " acc_x"}, {12'd0, last_x}, {12'd0, acc_x});
		end
		if (acc_y !== last_y) begin
			report_mismatch({test, " acc_y"}, {12'd0, last_y}, {12'd0, acc_y});
		end
		if (acc_z !== last_z) begin
			report_mismatch({test, " acc_z"}, {12'd0, last_z}, {12'd0, acc_z});
		end
	endtask

	task automatic test_reset();
		if (busy !== 1'b0) report_mismatch("reset busy", 32'd0, {31'd0, busy});
		if (done !== 1'b0) report_mismatch("reset done", 32'd0, {31'd0, done});
		if (nack !== 1'b0) report_mismatch("reset nack", 32'd0, {31'd0, nack});
		if (scl_oe !== 1'b0) report_mismatch("reset scl_oe", 32'd0, {31'd0, scl_oe});
		if (sda_oe !== 1'b0) report_mismatch("reset sda_oe", 32'd0, {31'd0, sda_oe});
		if (rd_data !== 8'd0) report_mismatch("reset rd_data", 32'd0, {24'd0, rd_data});
		if (temp !== 12'd0) report_mismatch("reset temp", 32'd0, {20'd0, temp});
		if (acc_x !== 20'd0) report_mismatch("reset acc_x", 32'd0, {12'd0, acc_x});
		if (acc_y !== 20'd0) report_mismatch("reset acc_y", 32'd0, {12'd0, acc_y});
		if (acc_z !== 20'd0) report_mismatch("reset acc_z", 32'd0, {12'd0, acc_z});
	endtask

	task automatic test_write();
		logic [7:0] a;
		logic [7:0] d;
		for (int i = 0; i < 4; i++) begin
			a = lcg_byte();
			d = lcg_byte();
			cpu_transfer(OP_WRITE, a, d, "write");
			exp_regs[a] = d;
			if (nack !== 1'b0) report_mismatch("write nack", 32'd0, {31'd0, nack});
			if (slave.regs[a] !== d) begin
				report_mismatch("write", {24'd0, d}, {24'd0, slave.regs[a]});
			end
		end
	endtask

	task automatic test_read();
		logic [7:0] a;
		for (int i = 0; i < 4; i++) begin
			a = lcg_byte();
			cpu_transfer(OP_READ, a, 8'd0, "read");
			if (nack !== 1'b0) report_mismatch("read nack", 32'd0, {31'd0, nack});
			if (rd_data !== exp_regs[a]) begin
				report_mismatch("read", {24'd0, exp_regs[a]}, {24'd0, rd_data});
			end
		end
	endtask

	task automatic test_burst();
		logic [7:0] b [BURST_LEN];
		for (int i = 0; i < BURST_LEN; i++) begin
			b[i] = lcg_byte();
			preload_reg(REG_TEMP2 + 8'(i), b[i]);
		end
		// low nibble of TEMP2 then TEMP1
		// each axis is data3, data2 and the high nibble of data1
		last_temp = {b[0][3:0], b[1]};
		last_x = {b[2], b[3], b[4][7:4]};
		last_y = {b[5], b[6], b[7][7:4]};
		last_z = {b[8], b[9], b[10][7:4]};
		pulse_drdy();
		wait_done("burst");
		if (nack !== 1'b0) report_mismatch("burst nack", 32'd0, {31'd0, nack});
		check_samples("burst");
	endtask

	task automatic test_nack();
		logic [7:0] a;
		@(posedge clk);
		mute <= 1'b1;
		a = lcg_byte();
		cpu_transfer(OP_WRITE, a, ~exp_regs[a], "nack");
		if (nack !== 1'b1) report_mismatch("nack flag", 32'd1, {31'd0, nack});
		check_samples("nack");
		// a refused burst leaves the previous samples in place
		pulse_drdy();
		wait_done("nack burst");
		if (nack !== 1'b1) report_mismatch("nack burst flag", 32'd1, {31'd0, nack});
		check_samples("nack burst");
		for (int i = 0; i < 256; i++) begin
			if (slave.regs[8'(i)] !== exp_regs[8'(i)]) begin
				report_mismatch("nack regs", {24'd0, exp_regs[8'(i)]},
					{24'd0, slave.regs[8'(i)]});
			end
		end
		@(posedge clk);
		mute <= 1'b0;
	endtask

	task automatic test_ignored();
		logic [7:0] a1;
		logic [7:0] d1;
		logic [7:0] a2;
		int         n;
		logic       extra;
		a1 = lcg_byte();
		d1 = lcg_byte();
		a2 = a1 ^ 8'h55;
		@(posedge clk);
		start    <= 1'b1;
		op       <= OP_WRITE;
		reg_addr <= a1;
		wr_data  <= d1;
		@(posedge clk);
		start <= 1'b0;
		n = 0;
		while (!busy && n < 100) begin
			@(posedge clk);
			n++;
		end
		if (!busy) begin
			errors++;
			$display("error ignored: busy never rose after the request");
		end
		// second request lands while busy
		start    <= 1'b1;
		reg_addr <= a2;
		wr_data  <= ~exp_regs[a2];
		@(posedge clk);
		start <= 1'b0;
		wait_done("ignored");
		exp_regs[a1] = d1;
		if (nack !== 1'b0) report_mismatch("ignored nack", 32'd0, {31'd0, nack});
		if (slave.regs[a1] !== d1) begin
			report_mismatch("ignored", {24'd0, d1}, {24'd0, slave.regs[a1]});
		end
		n = 0;
		extra = 1'b0;
		while (n < DONE_TIMEOUT) begin
			@(posedge clk);
			if (done) extra = 1'b1;
			n++;
		end
		if (extra) begin
			errors++;
			$display("error ignored: a second transfer ran for a request given while busy");
		end
		if (slave.regs[a2] !== exp_regs[a2]) begin
			report_mismatch("ignored second", {24'd0, exp_regs[a2]}, {24'd0, slave.regs[a2]});
		end
	endtask

	initial begin
		errors    = 0;
		lcg_state = 32'd50;
		rst_n     = 1'b0;
		start     = 1'b0;
		op        = OP_WRITE;
		reg_addr  = 8'd0;
		wr_data   = 8'd0;
		drdy      = 1'b0;
		mute      = 1'b0;
		pre_we    = 1'b0;
		pre_addr  = 8'd0;
		pre_data  = 8'd0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		test_reset();
		for (int i = 0; i < 256; i++) begin
			preload_reg(8'(i), lcg_byte());
		end
		test_write();
		test_read();
		test_burst();
		test_nack();
		test_ignored();
		$display("tests run: 6, errors: %0d", errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
hw/adxl355_pkg.sv
hw/i2c_bit_timer.sv
hw/i2c_seq_fsm.sv
hw/i2c_byte_shifter.sv
hw/sensor_sample_reg.sv
hw/adxl355_i2c_top.sv
sim/adxl355_slave_model.sv
sim/adxl355_i2c_assert.sv
sim/tb_adxl355_i2c.sv

// File: Makefile
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_adxl355_i2c: flist.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_adxl355_i2c -f flist.f

run: obj_dir/Vtb_adxl355_i2c
	./obj_dir/Vtb_adxl355_i2c > sim.log 2>&1; cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
